// File: hyper_defs.svh
`ifndef HYPER_DEFS_SVH
`define HYPER_DEFS_SVH

// Byte address width of the AXI4-Lite port
`define AXI_ADDR_WIDTH 16

// Number of HyperRAM chips on the bus
`define HYPER_NUM_CHIPS 2

// Depth of one chip in 16-bit words
`define HYPER_BANK_WORDS 256

`endif

// File: axi_lite_pkg.sv
`default_nettype none

`include "hyper_defs.svh"

package axi_lite_pkg;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [31:0]                data_t;
    typedef logic [3:0]                 strb_t;

    // Master to slave, all five channels
    typedef struct packed {
        addr_t aw_addr;
        logic  aw_valid;
        data_t w_data;
        strb_t w_strb;
        logic  w_valid;
        logic  b_ready;
        addr_t ar_addr;
        logic  ar_valid;
        logic  r_ready;
    } axi_req_t;

    // Slave to master
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  ar_ready;
        resp_t b_resp;
        logic  b_valid;
        data_t r_data;
        resp_t r_resp;
        logic  r_valid;
    } axi_rsp_t;

endpackage

`default_nettype wire

// File: hyper_pkg.sv
`default_nettype none

`include "hyper_defs.svh"

package hyper_pkg;

    typedef logic [15:0]                         hyper_word_t;
    typedef logic [`AXI_ADDR_WIDTH-2:0]          hyper_addr_t;
    typedef logic [1:0]                          hyper_blen_t;
    typedef logic [$clog2(`HYPER_NUM_CHIPS)-1:0] hyper_chip_t;

    // One transfer, address counted in 16-bit words
    typedef struct packed {
        logic        write;
        hyper_addr_t addr;
        hyper_blen_t blen;
        hyper_chip_t chip;
    } hyper_tf_t;

    typedef struct packed {
        hyper_word_t data;
        logic [1:0]  strb;
        logic        last;
    } hyper_tx_t;

    typedef struct packed {
        hyper_word_t data;
        logic        last;
    } hyper_rx_t;

    // CA fields, bit 47 down to bit 0
    typedef struct packed {
        logic        rd;
        logic        addr_space;
        logic        burst_lin;
        logic [28:0] upper;
        logic [12:0] rsvd;
        logic [2:0]  lower;
    } hyper_ca_t;

    // Same 48 bits as fields or as three bus words, w[2] goes first
    typedef union packed {
        hyper_ca_t              f;
        logic [2:0][15:0]       w;
    } hyper_ca_u;

    typedef struct packed {
        hyper_word_t data;
        logic [1:0]  strb;
        logic        ca;
        logic        dat;
    } hyper_bus_t;

endpackage

`default_nettype wire

// File: hyper_axi_front.sv
`default_nettype none

`include "hyper_defs.svh"

module hyper_axi_front (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  axi_lite_pkg::axi_req_t axi_req_i,
    output axi_lite_pkg::axi_rsp_t axi_rsp_o,
    output hyper_pkg::hyper_tf_t   trans_o,
    output logic                   trans_valid_o,
    input  logic                   trans_ready_i,
    output hyper_pkg::hyper_tx_t   tx_o,
    output logic                   tx_valid_o,
    input  logic                   tx_ready_i,
    input  hyper_pkg::hyper_rx_t   rx_i,
    input  logic                   rx_valid_i,
    input  logic                   b_valid_i
);

    // Byte offset bits inside one chip
    localparam int unsigned OFFS_W = $clog2(2 * `HYPER_BANK_WORDS);

    typedef enum logic [2:0] {
        FE_IDLE,
        FE_TRANS,
        FE_TX,
        FE_WAIT,
        FE_RESP
    } fe_state_e;

    fe_state_e                   state_q;
    logic                        rr_q;
    logic                        word_q;
    logic                        b_valid_q;
    logic                        r_valid_q;

    logic                        write_q;
    axi_lite_pkg::addr_t         addr_q;
    logic [1:0][15:0]            wdata_q;
    logic [1:0][1:0]             strb_q;
    logic [1:0][15:0]            rdata_q;
    axi_lite_pkg::resp_t         resp_q;

    logic                        wr_req;
    logic                        rd_req;
    logic                        grant_wr;
    logic                        grant_rd;
    axi_lite_pkg::addr_t         sel_addr;
    logic                        sel_err;

    // ========================================================================
    // Arbitration and chip decoding
    // ========================================================================

    assign wr_req = axi_req_i.aw_valid & axi_req_i.w_valid;
    assign rd_req = axi_req_i.ar_valid;

    // rr_q low favours the write side on a tie
    assign grant_wr = (state_q == FE_IDLE) & wr_req & (~rd_req | ~rr_q);
    assign grant_rd = (state_q == FE_IDLE) & rd_req & (~wr_req | rr_q);

    assign sel_addr = grant_wr ? axi_req_i.aw_addr : axi_req_i.ar_addr;

    // Anything past the last chip is unmapped
    assign sel_err = sel_addr[`AXI_ADDR_WIDTH-1:OFFS_W] >= `HYPER_NUM_CHIPS;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= FE_IDLE;
            rr_q      <= 1'b0;
            word_q    <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            case (state_q)
                FE_IDLE: begin
                    if (grant_wr | grant_rd) begin
                        rr_q   <= ~rr_q;
                        word_q <= 1'b0;
                        if (sel_err) begin
                            b_valid_q <= grant_wr;
                            r_valid_q <= grant_rd;
                            state_q   <= FE_RESP;
                        end else begin
                            state_q <= FE_TRANS;
                        end
                    end
                end
                FE_TRANS: begin
                    if (trans_ready_i) begin
                        state_q <= write_q ? FE_TX : FE_WAIT;
                    end
                end
                FE_TX: begin
                    if (tx_ready_i) begin
                        word_q <= ~word_q;
                        if (word_q) begin
                            state_q <= FE_WAIT;
                        end
                    end
                end
                FE_WAIT: begin
                    if (rx_valid_i) begin
                        word_q <= ~word_q;
                        if (rx_i.last) begin
                            r_valid_q <= 1'b1;
                            state_q   <= FE_RESP;
                        end
                    end
                    if (b_valid_i) begin
                        b_valid_q <= 1'b1;
                        state_q   <= FE_RESP;
                    end
                end
                FE_RESP: begin
                    if ((b_valid_q & axi_req_i.b_ready) | (r_valid_q & axi_req_i.r_ready)) begin
                        b_valid_q <= 1'b0;
                        r_valid_q <= 1'b0;
                        state_q   <= FE_IDLE;
                    end
                end
                default: state_q <= FE_IDLE;
            endcase
        end
    end

    // Latched access and read coalescing
    always_ff @(posedge clk_i) begin
        if (grant_wr | grant_rd) begin
            write_q <= grant_wr;
            addr_q  <= sel_addr;
            wdata_q <= axi_req_i.w_data;
            strb_q  <= axi_req_i.w_strb;
            resp_q  <= sel_err ? axi_lite_pkg::RESP_SLVERR : axi_lite_pkg::RESP_OKAY;
        end
        if ((state_q == FE_WAIT) && rx_valid_i) begin
            rdata_q[word_q] <= rx_i.data;
        end
    end

    // ========================================================================
    // HyperBus side
    // ========================================================================

    assign trans_valid_o = (state_q == FE_TRANS);
    assign trans_o.write = write_q;
    assign trans_o.addr  = addr_q[`AXI_ADDR_WIDTH-1:1];
    assign trans_o.blen  = hyper_pkg::hyper_blen_t'(2);
    assign trans_o.chip  = addr_q[OFFS_W +: $bits(hyper_pkg::hyper_chip_t)];

    // Low half goes out first
    assign tx_valid_o = (state_q == FE_TX);
    assign tx_o.data  = wdata_q[word_q];
    assign tx_o.strb  = strb_q[word_q];
    assign tx_o.last  = word_q;

    // AXI responses
    assign axi_rsp_o.aw_ready = grant_wr;
    assign axi_rsp_o.w_ready  = grant_wr;
    assign axi_rsp_o.ar_ready = grant_rd;
    assign axi_rsp_o.b_resp   = resp_q;
    assign axi_rsp_o.b_valid  = b_valid_q;
    assign axi_rsp_o.r_data   = rdata_q;
    assign axi_rsp_o.r_resp   = resp_q;
    assign axi_rsp_o.r_valid  = r_valid_q;

endmodule

`default_nettype wire

// File: hyper_ca_sequencer.sv
`default_nettype none

`include "hyper_defs.svh"

module hyper_ca_sequencer (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  hyper_pkg::hyper_tf_t         trans_i,
    input  logic                         trans_valid_i,
    output logic                         trans_ready_o,
    input  hyper_pkg::hyper_tx_t         tx_i,
    input  logic                         tx_valid_i,
    output logic                         tx_ready_o,
    output hyper_pkg::hyper_bus_t        bus_o,
    output logic [`HYPER_NUM_CHIPS-1:0]  cs_o
);

    typedef enum logic [1:0] {
        SQ_IDLE,
        SQ_CA,
        SQ_WDATA,
        SQ_RWAIT
    } sq_state_e;

    sq_state_e                   state_q;
    logic [1:0]                  cnt_q;
    logic [`HYPER_NUM_CHIPS-1:0] cs_q;

    logic                        write_q;
    hyper_pkg::hyper_blen_t      blen_q;
    hyper_pkg::hyper_ca_u        ca_q;
    hyper_pkg::hyper_ca_u        ca_d;

    // Linear burst into memory space
    always_comb begin
        ca_d            = '0;
        ca_d.f.rd         = ~trans_i.write;
        ca_d.f.addr_space = 1'b0;
        ca_d.f.burst_lin  = 1'b1;
        ca_d.f.upper      = 29'(trans_i.addr >> 3);
        ca_d.f.lower      = trans_i.addr[2:0];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SQ_IDLE;
            cnt_q   <= '0;
            cs_q    <= '0;
        end else begin
            case (state_q)
                SQ_IDLE: begin
                    if (trans_valid_i) begin
                        cnt_q   <= '0;
                        cs_q    <= `HYPER_NUM_CHIPS'(1) << trans_i.chip;
                        state_q <= SQ_CA;
                    end
                end
                SQ_CA: begin
                    if (cnt_q == 2'd2) begin
                        cnt_q   <= '0;
                        state_q <= write_q ? SQ_WDATA : SQ_RWAIT;
                    end else begin
                        cnt_q <= cnt_q + 2'd1;
                    end
                end
                SQ_WDATA: begin
                    if (tx_valid_i && tx_i.last) begin
                        cs_q    <= '0;
                        state_q <= SQ_IDLE;
                    end
                end
                SQ_RWAIT: begin
                    // Bank streams one word per cycle
                    if (cnt_q == blen_q - 2'd1) begin
                        cs_q    <= '0;
                        state_q <= SQ_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 2'd1;
                    end
                end
                default: state_q <= SQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == SQ_IDLE) && trans_valid_i) begin
            ca_q    <= ca_d;
            write_q <= trans_i.write;
            blen_q  <= trans_i.blen;
        end else if (state_q == SQ_CA) begin
            ca_q.w <= {ca_q.w[1:0], 16'h0000};
        end
    end

    assign trans_ready_o = (state_q == SQ_IDLE);
    assign cs_o          = cs_q;

    always_comb begin
        bus_o      = '0;
        tx_ready_o = 1'b0;
        case (state_q)
            SQ_CA: begin
                bus_o.data = ca_q.w[2];
                bus_o.ca   = 1'b1;
            end
            SQ_WDATA: begin
                tx_ready_o = 1'b1;
                bus_o.data = tx_i.data;
                bus_o.strb = tx_i.strb;
                bus_o.dat  = tx_valid_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hyper_mem_bank.sv
`default_nettype none

`include "hyper_defs.svh"

module hyper_mem_bank (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  cs_i,
    input  hyper_pkg::hyper_bus_t bus_i,
    output hyper_pkg::hyper_rx_t  rd_o,
    output logic                  rd_valid_o,
    output logic                  wr_done_o
);

    localparam int unsigned AW = $clog2(`HYPER_BANK_WORDS);

    logic [1:0][7:0]      mem_q [`HYPER_BANK_WORDS];
    hyper_pkg::hyper_ca_u ca_q;
    hyper_pkg::hyper_ca_u ca_d;
    logic [1:0]           ca_cnt_q;
    logic                 beat_q;
    logic                 rd_busy_q;
    logic [AW-1:0]        addr_q;
    logic [AW-1:0]        ca_addr;
    logic                 ca_take;
    logic                 ca_done;
    logic                 wr_take;

    assign ca_take = cs_i & bus_i.ca;
    assign ca_done = ca_take & (ca_cnt_q == 2'd2);
    assign wr_take = cs_i & bus_i.dat;

    // Incoming word shifts in at the bottom
    assign ca_d.w  = {ca_q.w[1:0], bus_i.data};
    assign ca_addr = AW'({ca_d.f.upper, ca_d.f.lower});

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ca_cnt_q   <= '0;
            beat_q     <= 1'b0;
            rd_busy_q  <= 1'b0;
            rd_o       <= '0;
            rd_valid_o <= 1'b0;
            wr_done_o  <= 1'b0;
        end else begin
            rd_valid_o <= 1'b0;
            rd_o.last  <= 1'b0;
            wr_done_o  <= wr_take & beat_q;
            if (ca_take) begin
                ca_cnt_q <= ca_done ? 2'd0 : ca_cnt_q + 2'd1;
            end
            if (ca_done) begin
                beat_q <= 1'b0;
            end else if (wr_take) begin
                beat_q <= ~beat_q;
            end
            // First read word leaves right after the last CA word
            if (ca_done && ca_d.f.rd) begin
                rd_busy_q  <= 1'b1;
                rd_valid_o <= 1'b1;
                rd_o.data  <= mem_q[ca_addr];
            end else if (rd_busy_q) begin
                rd_busy_q  <= 1'b0;
                rd_valid_o <= 1'b1;
                rd_o.data  <= mem_q[addr_q];
                rd_o.last  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ca_take) begin
            ca_q <= ca_d;
        end
        if (ca_done) begin
            addr_q <= ca_d.f.rd ? ca_addr + AW'(1) : ca_addr;
        end else if (wr_take) begin
            addr_q <= addr_q + AW'(1);
        end
        for (int b = 0; b < 2; b++) begin
            if (wr_take && bus_i.strb[b]) begin
                mem_q[addr_q][b] <= bus_i.data[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: hyper_rx_merge.sv
`default_nettype none

`include "hyper_defs.svh"

module hyper_rx_merge (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    input  hyper_pkg::hyper_rx_t [`HYPER_NUM_CHIPS-1:0]      rd_i,
    input  logic [`HYPER_NUM_CHIPS-1:0]                      rd_valid_i,
    input  logic [`HYPER_NUM_CHIPS-1:0]                      wr_done_i,
    output hyper_pkg::hyper_rx_t                             rx_o,
    output logic                                             rx_valid_o,
    output logic                                             b_valid_o
);

    hyper_pkg::hyper_rx_t rd_sel;

    // At most one bank talks at a time
    always_comb begin
        rd_sel = '0;
        for (int i = 0; i < `HYPER_NUM_CHIPS; i++) begin
            if (rd_valid_i[i]) begin
                rd_sel = rd_i[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_valid_o <= 1'b0;
            b_valid_o  <= 1'b0;
        end else begin
            rx_valid_o <= |rd_valid_i;
            b_valid_o  <= |wr_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rx_o <= rd_sel;
    end

endmodule

`default_nettype wire

// File: hyper_subsys_top.sv
`default_nettype none

`include "hyper_defs.svh"

module hyper_subsys_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  axi_lite_pkg::axi_req_t axi_req_i,
    output axi_lite_pkg::axi_rsp_t axi_rsp_o
);

    hyper_pkg::hyper_tf_t                         trans;
    logic                                         trans_valid;
    logic                                         trans_ready;
    hyper_pkg::hyper_tx_t                         tx;
    logic                                         tx_valid;
    logic                                         tx_ready;
    hyper_pkg::hyper_rx_t                         rx;
    logic                                         rx_valid;
    logic                                         b_valid;
    hyper_pkg::hyper_bus_t                        bus;
    logic [`HYPER_NUM_CHIPS-1:0]                  cs;
    hyper_pkg::hyper_rx_t [`HYPER_NUM_CHIPS-1:0]  bank_rd;
    logic [`HYPER_NUM_CHIPS-1:0]                  bank_rd_valid;
    logic [`HYPER_NUM_CHIPS-1:0]                  bank_wr_done;

    hyper_axi_front i_front (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .axi_req_i     (axi_req_i),
        .axi_rsp_o     (axi_rsp_o),
        .trans_o       (trans),
        .trans_valid_o (trans_valid),
        .trans_ready_i (trans_ready),
        .tx_o          (tx),
        .tx_valid_o    (tx_valid),
        .tx_ready_i    (tx_ready),
        .rx_i          (rx),
        .rx_valid_i    (rx_valid),
        .b_valid_i     (b_valid)
    );

    hyper_ca_sequencer i_seq (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .trans_i       (trans),
        .trans_valid_i (trans_valid),
        .trans_ready_o (trans_ready),
        .tx_i          (tx),
        .tx_valid_i    (tx_valid),
        .tx_ready_o    (tx_ready),
        .bus_o         (bus),
        .cs_o          (cs)
    );

    for (genvar i = 0; i < `HYPER_NUM_CHIPS; i++) begin : gen_bank
        hyper_mem_bank i_bank (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .cs_i       (cs[i]),
            .bus_i      (bus),
            .rd_o       (bank_rd[i]),
            .rd_valid_o (bank_rd_valid[i]),
            .wr_done_o  (bank_wr_done[i])
        );
    end

    hyper_rx_merge i_merge (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .rd_i       (bank_rd),
        .rd_valid_i (bank_rd_valid),
        .wr_done_i  (bank_wr_done),
        .rx_o       (rx),
        .rx_valid_o (rx_valid),
        .b_valid_o  (b_valid)
    );

endmodule

`default_nettype wire

// File: hyper_subsys_checker.sv
`default_nettype none

`include "hyper_defs.svh"

module hyper_subsys_checker (
    input logic                        clk_i,
    input logic                        rst_ni,
    input axi_lite_pkg::axi_req_t      axi_req_i,
    input axi_lite_pkg::axi_rsp_t      axi_rsp_i,
    input logic [`HYPER_NUM_CHIPS-1:0] cs_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    // ========================================================================
    // AXI4-Lite response channels
    // ========================================================================

    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !axi_rsp_i.b_valid && !axi_rsp_i.r_valid)
        else begin
            $error("AXI response valid while in reset");
            fail_cnt++;
        end

    b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        axi_rsp_i.b_valid && !axi_req_i.b_ready
        |=> axi_rsp_i.b_valid && $stable(axi_rsp_i.b_resp))
        else begin
            $error("B response dropped or changed before ready");
            fail_cnt++;
        end

    r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        axi_rsp_i.r_valid && !axi_req_i.r_ready
        |=> axi_rsp_i.r_valid && $stable(axi_rsp_i.r_data) && $stable(axi_rsp_i.r_resp))
        else begin
            $error("R response dropped or changed before ready");
            fail_cnt++;
        end

    // AW and W are only taken together and only while both are valid
    aw_with_w: assert property (@(posedge clk_i) disable iff (!rst_ni)
        axi_rsp_i.aw_ready || axi_rsp_i.w_ready
        |-> axi_rsp_i.aw_ready && axi_rsp_i.w_ready
            && axi_req_i.aw_valid && axi_req_i.w_valid)
        else begin
            $error("aw_ready and w_ready not raised together with both valid");
            fail_cnt++;
        end

    cs_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(cs_i))
        else begin
            $error("More than one chip select active");
            fail_cnt++;
        end

endmodule

bind hyper_subsys_top hyper_subsys_checker i_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .axi_req_i (axi_req_i),
    .axi_rsp_i (axi_rsp_o),
    .cs_i      (cs)
);

`default_nettype wire

// File: tb_hyper_subsys.sv
`default_nettype none

`include "hyper_defs.svh"

module tb_hyper_subsys;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int PASSES       = 2;
    localparam int NUM_ENTRIES  = 18;
    localparam int WATCHDOG_NS  = PASSES * NUM_ENTRIES * 200 + RESET_CYCLES * CLK_PERIOD;
    localparam int MAP_BYTES    = 2 * `HYPER_BANK_WORDS * `HYPER_NUM_CHIPS;
    localparam int IDX_W        = $clog2(MAP_BYTES);
    localparam logic [31:0] SEED = 32'h90e4_f2eb;

    localparam axi_lite_pkg::resp_t R_OK  = axi_lite_pkg::RESP_OKAY;
    localparam axi_lite_pkg::resp_t R_ERR = axi_lite_pkg::RESP_SLVERR;

    typedef logic [IDX_W-1:0] idx_t;
    typedef enum logic [1:0] {OP_WR, OP_RD, OP_BOTH} op_e;

    typedef struct packed {
        op_e                 op;
        axi_lite_pkg::addr_t addr;
        axi_lite_pkg::data_t data;
        axi_lite_pkg::strb_t strb;
        axi_lite_pkg::resp_t resp;
    } entry_t;

    logic                   clk_i;
    logic                   rst_ni;
    axi_lite_pkg::axi_req_t axi_req;
    axi_lite_pkg::axi_rsp_t axi_rsp;

    entry_t                 tests [NUM_ENTRIES];
    logic [7:0]             ref_mem [MAP_BYTES];
    int                     err_cnt;
    int                     check_cnt;

    hyper_subsys_top DUT (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .axi_req_i (axi_req),
        .axi_rsp_o (axi_rsp)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ========================================================================
    // Reference memory of little endian bytes over both chips
    // ========================================================================

    function automatic void ref_write(input axi_lite_pkg::addr_t addr,
                                      input axi_lite_pkg::data_t data,
                                      input axi_lite_pkg::strb_t strb);
        // Unmapped addresses never reach a chip
        if (32'(addr) < MAP_BYTES) begin
            for (int k = 0; k < 4; k++) begin
                if (strb[k]) begin
                    ref_mem[idx_t'(addr) + idx_t'(k)] = data[8*k +: 8];
                end
            end
        end
    endfunction

    function automatic axi_lite_pkg::data_t ref_read(input axi_lite_pkg::addr_t addr);
        axi_lite_pkg::data_t val;
        for (int k = 0; k < 4; k++) begin
            val[8*k +: 8] = ref_mem[idx_t'(addr) + idx_t'(k)];
        end
        return val;
    endfunction

    function automatic string op_text(input op_e op);
        case (op)
            OP_WR:   return "write";
            OP_RD:   return "read";
            default: return "write+read";
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // Bank 1 starts at 0x200 and everything from 0x400 is unmapped
    task automatic load_table();
        tests[0]  = '{OP_WR,   16'h0010, 32'h1234_5678, 4'b1111, R_OK};
        tests[1]  = '{OP_WR,   16'h0210, 32'hcafe_f00d, 4'b1111, R_OK};
        tests[2]  = '{OP_RD,   16'h0010, 32'h0000_0000, 4'b0000, R_OK};
        tests[3]  = '{OP_RD,   16'h0210, 32'h0000_0000, 4'b0000, R_OK};
        tests[4]  = '{OP_WR,   16'h01fc, 32'ha5a5_5a5a, 4'b1111, R_OK};
        tests[5]  = '{OP_RD,   16'h01fc, 32'h0000_0000, 4'b0000, R_OK};
        tests[6]  = '{OP_WR,   16'h0010, 32'hffee_ddcc, 4'b0101, R_OK};
        tests[7]  = '{OP_RD,   16'h0010, 32'h0000_0000, 4'b0000, R_OK};
        tests[8]  = '{OP_WR,   16'h0210, 32'h1111_2222, 4'b1100, R_OK};
        tests[9]  = '{OP_RD,   16'h0210, 32'h0000_0000, 4'b0000, R_OK};
        tests[10] = '{OP_WR,   16'h0010, 32'h3333_4444, 4'b0011, R_OK};
        tests[11] = '{OP_RD,   16'h0010, 32'h0000_0000, 4'b0000, R_OK};
        tests[12] = '{OP_WR,   16'h0410, 32'hdead_beef, 4'b1111, R_ERR};
        tests[13] = '{OP_RD,   16'h0610, 32'h0000_0000, 4'b0000, R_ERR};
        tests[14] = '{OP_RD,   16'h0010, 32'h0000_0000, 4'b0000, R_OK};
        tests[15] = '{OP_BOTH, 16'h0210, 32'h7654_3210, 4'b1111, R_OK};
        tests[16] = '{OP_RD,   16'h0210, 32'h0000_0000, 4'b0000, R_OK};
        tests[17] = '{OP_BOTH, 16'h0010, 32'h0bad_f00d, 4'b1001, R_OK};
    endtask

    // ========================================================================
    // One table entry is entered and left just after a rising edge
    // ========================================================================

    task automatic apply_entry(input entry_t e, input bit jitter);
        logic                want_wr;
        logic                want_rd;
        logic                got_b;
        logic                got_r;
        logic                b_first;
        logic                aw_hs;
        logic                w_hs;
        logic                w_seen;
        logic                ar_hs;
        axi_lite_pkg::resp_t b_resp;
        axi_lite_pkg::resp_t r_resp;
        axi_lite_pkg::data_t r_data;
        axi_lite_pkg::data_t exp_pre;
        axi_lite_pkg::data_t exp_post;

        want_wr = (e.op != OP_RD);
        want_rd = (e.op != OP_WR);
        got_b   = ~want_wr;
        got_r   = ~want_rd;
        b_first = 1'b0;
        w_seen  = 1'b0;
        b_resp  = '0;
        r_resp  = '0;
        r_data  = '0;

        // Memory as a read sees it before and after the write
        exp_pre = ref_read(e.addr);
        if (want_wr) begin
            ref_write(e.addr, e.data, e.strb);
        end
        exp_post = ref_read(e.addr);

        axi_req.aw_addr  <= e.addr;
        axi_req.aw_valid <= want_wr;
        axi_req.w_data   <= e.data;
        axi_req.w_strb   <= e.strb;
        axi_req.w_valid  <= want_wr;
        axi_req.ar_addr  <= e.addr;
        axi_req.ar_valid <= want_rd;

        while (!(got_b && got_r)) begin
            axi_req.b_ready <= jitter ? 1'($urandom_range(1, 0)) : 1'b1;
            axi_req.r_ready <= jitter ? 1'($urandom_range(1, 0)) : 1'b1;
            @(negedge clk_i);
            aw_hs = axi_req.aw_valid & axi_rsp.aw_ready;
            w_hs  = axi_req.w_valid & axi_rsp.w_ready;
            ar_hs = axi_req.ar_valid & axi_rsp.ar_ready;
            if (w_hs) begin
                w_seen = 1'b1;
            end
            if (!got_b && axi_rsp.b_valid && axi_req.b_ready) begin
                got_b   = 1'b1;
                b_resp  = axi_rsp.b_resp;
                b_first = ~got_r;
            end
            if (!got_r && axi_rsp.r_valid && axi_req.r_ready) begin
                got_r  = 1'b1;
                r_resp = axi_rsp.r_resp;
                r_data = axi_rsp.r_data;
            end
            @(posedge clk_i);
            if (aw_hs) begin
                axi_req.aw_valid <= 1'b0;
            end
            if (w_hs) begin
                axi_req.w_valid <= 1'b0;
            end
            if (ar_hs) begin
                axi_req.ar_valid <= 1'b0;
            end
        end

        if (want_wr) begin
            check("w accepted", 32'(w_seen), 32'd1);
            check("b_resp", 32'(b_resp), 32'(e.resp));
        end
        if (want_rd) begin
            check("r_resp", 32'(r_resp), 32'(e.resp));
            // Write granted first means the read sees the new data
            if (e.resp == R_OK) begin
                check("r_data", r_data, (e.op == OP_BOTH && !b_first) ? exp_pre : exp_post);
            end
        end
    endtask

    initial begin
        int err_before;

        clk_i   = 1'b0;
        rst_ni  = 1'b1;
        axi_req = '0;
        err_cnt   = 0;
        check_cnt = 0;
        void'($urandom(SEED));
        load_table();

        // Falling edge so the asynchronous reset takes hold at once
        #1 rst_ni = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        // Second pass replays the table under random back-pressure
        for (int p = 0; p < PASSES; p++) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                err_before = err_cnt;
                apply_entry(tests[i], p != 0);
                $display("pass %0d entry %0d %s at %h: %s", p, i, op_text(tests[i].op),
                         tests[i].addr, (err_cnt == err_before) ? "ok" : "mismatch");
            end
        end

        $display("%0d entries, %0d checks, %0d mismatches, %0d assertion failures",
                 PASSES * NUM_ENTRIES, check_cnt, err_cnt, DUT.i_checker.fail_cnt);
        if (err_cnt == 0 && DUT.i_checker.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the table did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
axi_lite_pkg.sv
hyper_pkg.sv
hyper_axi_front.sv
hyper_ca_sequencer.sv
hyper_mem_bank.sv
hyper_rx_merge.sv
hyper_subsys_top.sv
hyper_subsys_checker.sv
tb_hyper_subsys.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_hyper_subsys -f vlog.f
./obj_dir/Vtb_hyper_subsys > sim.log 2>&1
cat sim.log

if grep -q "Everything OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
